//--- include/ldpc_config.svh
`ifndef LDPC_CONFIG_SVH
`define LDPC_CONFIG_SVH

// lifting size, bits per block
`define LDPC_ZC 2

// information block columns of the base graph
`define LDPC_KB 10

// block rows solved for core parity
`define LDPC_CORE_ROWS 4

// extension block rows, one parity block each
`define LDPC_EXT_ROWS 38

// CRC field at the encoder input
`define LDPC_CRC_W 16

// full output word including zero pad
`define LDPC_CW_W 128

// leading message blocks left out of the codeword
`define LDPC_PUNCT 2

`endif

//--- logic/ldpc_pkg.sv
`include "ldpc_config.svh"

package ldpc_pkg;

    typedef logic [`LDPC_ZC-1:0] block_t;                         // one lifted block
    typedef logic [`LDPC_KB*`LDPC_ZC-1:0] msg_t;                  // zero-extended message
    typedef logic signed [3:0] shift_t;                           // -1 marks a null entry
    typedef logic [`LDPC_CORE_ROWS*`LDPC_ZC-1:0] core_parity_t;   // block 0 in low bits
    typedef logic [`LDPC_EXT_ROWS*`LDPC_ZC-1:0] ext_parity_t;     // block 0 in low bits
    typedef logic [`LDPC_CW_W-1:0] codeword_t;

    // message columns of the core rows
    parameter shift_t bg_core_shift [`LDPC_CORE_ROWS][`LDPC_KB] = '{
        '{ 1,  1,  0,  0, -1, -1,  1, -1, -1,  1},
        '{ 1, -1, -1,  0,  1,  1,  0,  0,  0,  0},
        '{ 1,  0, -1,  0,  0, -1, -1, -1,  0, -1},
        '{-1,  0,  0, -1,  0,  0,  1,  0,  0,  0}
    };

    // message columns of the extension rows
    parameter shift_t bg_ext_msg_shift [`LDPC_EXT_ROWS][`LDPC_KB] = '{
        '{ 1,  0, -1, -1, -1, -1, -1, -1, -1, -1},   // row 0
        '{ 1,  1, -1, -1, -1,  0, -1,  1, -1, -1},
        '{ 1, -1, -1, -1, -1,  0, -1,  1, -1,  0},
        '{-1,  1, -1, -1, -1,  1, -1,  0, -1, -1},
        '{ 0,  0, -1, -1, -1, -1, -1, -1, -1, -1},
        '{-1,  1, -1, -1, -1, -1, -1, -1,  1, -1},
        '{ 1,  1, -1, -1, -1, -1,  0,  1, -1, -1},
        '{ 1, -1, -1, -1, -1, -1, -1,  0, -1,  0},
        '{-1,  1, -1,  1, -1, -1, -1, -1, -1, -1},
        '{ 1,  0, -1, -1, -1, -1, -1, -1,  0, -1},
        '{-1,  1, -1, -1, -1, -1,  1, -1, -1, -1},   // row 10
        '{ 1, -1, -1, -1, -1, -1, -1, -1, -1, -1},
        '{-1,  1, -1, -1, -1, -1, -1, -1, -1,  0},
        '{-1,  0, -1, -1, -1,  0, -1, -1, -1, -1},
        '{ 0, -1, -1, -1, -1, -1,  0,  0, -1, -1},
        '{ 1,  0, -1, -1, -1, -1, -1, -1, -1, -1},
        '{-1,  0, -1, -1,  1, -1, -1, -1, -1, -1},
        '{ 0, -1, -1, -1, -1, -1, -1, -1,  0, -1},
        '{-1,  0,  1, -1, -1, -1, -1, -1, -1, -1},
        '{ 1, -1, -1,  1, -1,  0, -1, -1, -1, -1},
        '{-1,  0,  1, -1, -1, -1, -1, -1, -1,  0},   // row 20
        '{ 0, -1, -1, -1, -1,  0, -1, -1, -1, -1},
        '{-1, -1,  1, -1, -1, -1, -1,  1, -1, -1},
        '{ 0, -1, -1, -1, -1, -1,  1, -1, -1, -1},
        '{-1,  0,  1, -1, -1,  1, -1, -1, -1, -1},
        '{ 0, -1, -1, -1,  0, -1, -1, -1, -1, -1},
        '{-1, -1,  1, -1, -1,  0, -1,  1, -1,  0},
        '{-1,  0, -1, -1, -1, -1, -1, -1, -1, -1},
        '{ 0, -1, -1, -1, -1,  0, -1, -1, -1, -1},
        '{-1, -1,  0, -1, -1, -1, -1,  0, -1, -1},
        '{ 1, -1, -1, -1, -1, -1, -1, -1, -1, -1},   // row 30
        '{-1,  1, -1, -1, -1,  0, -1, -1, -1, -1},
        '{ 0, -1,  0, -1, -1, -1, -1,  0, -1, -1},
        '{-1, -1, -1, -1, -1, -1, -1, -1, -1, -1},   // no message taps
        '{-1,  1, -1, -1, -1,  0, -1, -1, -1, -1},
        '{ 1, -1, -1, -1, -1, -1, -1,  0, -1, -1},
        '{-1, -1,  0, -1, -1, -1, -1, -1, -1, -1},
        '{-1,  1, -1, -1, -1,  1, -1, -1, -1, -1}
    };

    // core parity columns of the extension rows
    parameter shift_t bg_ext_par_shift [`LDPC_EXT_ROWS][`LDPC_CORE_ROWS] = '{
        '{-1,  1, -1, -1},   // row 0
        '{-1,  1, -1, -1},
        '{-1,  0, -1, -1},
        '{-1,  1, -1,  0},
        '{-1, -1,  0, -1},
        '{ 1,  1, -1, -1},
        '{-1, -1, -1, -1},
        '{-1, -1, -1,  0},
        '{-1,  0, -1, -1},
        '{-1, -1, -1,  0},
        '{-1,  1, -1,  0},   // row 10
        '{ 1,  1, -1, -1},
        '{-1,  0,  0, -1},
        '{-1,  0,  0, -1},
        '{-1, -1, -1, -1},
        '{ 1, -1, -1, -1},
        '{-1,  1, -1, -1},
        '{-1, -1, -1,  0},
        '{-1, -1, -1, -1},
        '{-1, -1, -1, -1},
        '{-1, -1, -1, -1},   // row 20
        '{-1, -1, -1, -1},
        '{-1, -1,  0,  0},
        '{-1, -1, -1, -1},
        '{-1, -1, -1, -1},
        '{-1, -1, -1, -1},
        '{-1, -1, -1, -1},
        '{-1, -1, -1,  1},
        '{-1, -1,  0, -1},
        '{ 1, -1, -1, -1},
        '{-1, -1,  1,  0},   // row 30
        '{-1,  1, -1, -1},
        '{-1, -1, -1, -1},
        '{ 1, -1, -1,  1},
        '{-1,  0, -1, -1},
        '{-1, -1,  0, -1},
        '{ 1, -1, -1,  0},
        '{-1,  0, -1, -1}
    };

    // output bit m takes input bit (m+s) mod zc, a null entry gives zero
    function automatic block_t cyclic_shift(block_t blk, shift_t sh);
        block_t res;
        res = '0;
        if (sh != -4'sd1) begin
            for (int m = 0; m < `LDPC_ZC; m++) begin
                res[m] = blk[(m + int'(sh)) % `LDPC_ZC];
            end
        end
        return res;
    endfunction

endpackage

//--- logic/ldpc_core_parity.sv
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpc_core_parity (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   start,
    input  logic                   data_in,
    input  logic [`LDPC_CRC_W-1:0] crc_in,
    output ldpc_pkg::msg_t         msg,
    output logic                   stage_valid,
    output ldpc_pkg::core_parity_t core_parity
);

    localparam int MSG_PAD = `LDPC_KB * `LDPC_ZC - `LDPC_CRC_W - 1;   // top message bits, always 0

    ldpc_pkg::msg_t   msg_next;
    ldpc_pkg::block_t row_sum [`LDPC_CORE_ROWS];
    ldpc_pkg::block_t row_total;
    ldpc_pkg::block_t par0;
    ldpc_pkg::block_t par1;
    ldpc_pkg::block_t par2;
    ldpc_pkg::block_t par3;

    assign msg_next = {{MSG_PAD{1'b0}}, crc_in, data_in};   // data bit in lsb

    // input stage, one request per cycle with start high
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            msg         <= '0;
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= start;
            if (start) begin
                msg <= msg_next;
            end
        end
    end

    // row sums over the message columns of each core row
    always_comb begin
        for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < `LDPC_KB; c++) begin
                row_sum[r] = row_sum[r] ^ ldpc_pkg::cyclic_shift(
                    msg[c*`LDPC_ZC +: `LDPC_ZC], ldpc_pkg::bg_core_shift[r][c]);
            end
        end
    end

    // double-diagonal solve with the branch fixed
    assign row_total = row_sum[0] ^ row_sum[1] ^ row_sum[2] ^ row_sum[3];
    assign par0      = ldpc_pkg::cyclic_shift(row_total, 4'sd1);   // rotate by one
    assign par1      = par0 ^ row_sum[0];
    assign par2      = par1 ^ row_sum[1];
    assign par3      = par0 ^ row_sum[3];

    assign core_parity = {par3, par2, par1, par0};

endmodule

//--- logic/ldpc_ext_parity.sv
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpc_ext_parity (
    input  logic                   CLK,
    input  logic                   RST,
    input  ldpc_pkg::msg_t         msg,
    input  ldpc_pkg::core_parity_t core_parity,
    input  logic                   stage_valid,
    output ldpc_pkg::codeword_t    codeword,
    output logic                   valid
);

    localparam int SYS_LO = `LDPC_PUNCT * `LDPC_ZC;   // first transmitted message bit
    localparam int SYS_W  = `LDPC_KB * `LDPC_ZC - SYS_LO;
    localparam int PAR_W  = (`LDPC_CORE_ROWS + `LDPC_EXT_ROWS) * `LDPC_ZC;
    localparam int PAD_W  = `LDPC_CW_W - PAR_W - SYS_W;

    ldpc_pkg::ext_parity_t ext_parity;
    ldpc_pkg::codeword_t   cw_next;

    // each extension block is a message sum xor a core parity sum
    always_comb begin
        ldpc_pkg::block_t msg_sum;
        ldpc_pkg::block_t par_sum;
        for (int i = 0; i < `LDPC_EXT_ROWS; i++) begin
            msg_sum = '0;
            par_sum = '0;
            for (int c = 0; c < `LDPC_KB; c++) begin
                msg_sum = msg_sum ^ ldpc_pkg::cyclic_shift(
                    msg[c*`LDPC_ZC +: `LDPC_ZC], ldpc_pkg::bg_ext_msg_shift[i][c]);
            end
            for (int j = 0; j < `LDPC_CORE_ROWS; j++) begin
                par_sum = par_sum ^ ldpc_pkg::cyclic_shift(
                    core_parity[j*`LDPC_ZC +: `LDPC_ZC], ldpc_pkg::bg_ext_par_shift[i][j]);
            end
            ext_parity[i*`LDPC_ZC +: `LDPC_ZC] = msg_sum ^ par_sum;
        end
    end

    // punctured layout, systematic part at the bottom
    assign cw_next = {
        {PAD_W{1'b0}},
        ext_parity,
        core_parity,
        msg[`LDPC_KB*`LDPC_ZC-1:SYS_LO]
    };

    // output stage, word holds until the next request
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            codeword <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= stage_valid;
            if (stage_valid) begin
                codeword <= cw_next;
            end
        end
    end

endmodule

//--- logic/ldpc_encoder.sv
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpc_encoder (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   start,
    input  logic                   data_in,
    input  logic [`LDPC_CRC_W-1:0] crc_in,
    output ldpc_pkg::codeword_t    codeword,
    output logic                   valid
);

    ldpc_pkg::msg_t         msg;
    ldpc_pkg::core_parity_t core_parity;
    logic                   stage_valid;

    // stage 1, message capture and core parity
    ldpc_core_parity u_core (
        .CLK         (CLK),
        .RST         (RST),
        .start       (start),
        .data_in     (data_in),
        .crc_in      (crc_in),
        .msg         (msg),
        .stage_valid (stage_valid),
        .core_parity (core_parity)
    );

    // stage 2, extension parity and codeword register
    ldpc_ext_parity u_ext (
        .CLK         (CLK),
        .RST         (RST),
        .msg         (msg),
        .core_parity (core_parity),
        .stage_valid (stage_valid),
        .codeword    (codeword),
        .valid       (valid)
    );

endmodule

//--- tests/ldpc_properties.sv
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpc_properties (
    input logic                CLK,
    input logic                RST,
    input logic                start,
    input logic                valid,
    input ldpc_pkg::codeword_t codeword
);

    localparam int PAD_LO = (`LDPC_KB - `LDPC_PUNCT + `LDPC_CORE_ROWS + `LDPC_EXT_ROWS) * `LDPC_ZC;

    // two-stage pipeline, result two edges after the request
    assert property (@(posedge CLK) disable iff (!RST) valid |-> $past(start, 2))
        else $error("valid without a start two edges earlier");

    assert property (@(posedge CLK) !RST |-> !valid)
        else $error("valid high while in reset");

    assert property (@(posedge CLK) disable iff (!RST) valid |-> (codeword[`LDPC_CW_W-1:PAD_LO] == '0))
        else $error("codeword pad bits not zero");

endmodule

bind ldpc_encoder ldpc_properties u_props (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .valid    (valid),
    .codeword (codeword)
);

//--- tests/ldpc_checker.sv
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpc_checker (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   start,
    input  logic                   data_in,
    input  logic [`LDPC_CRC_W-1:0] crc_in,
    input  logic [1:0]             test_id,
    input  ldpc_pkg::codeword_t    codeword,
    input  logic                   valid,
    input  logic                   end_check,
    output int                     mismatch_count,
    output int                     protocol_count,
    output int                     pending
);

    localparam int ZC     = `LDPC_ZC;
    localparam int MSG_W  = `LDPC_KB * `LDPC_ZC;
    localparam int SYS_LO = `LDPC_PUNCT * `LDPC_ZC;
    localparam int SYS_W  = MSG_W - SYS_LO;
    localparam int CORE_W = `LDPC_CORE_ROWS * `LDPC_ZC;

    ldpc_pkg::codeword_t exp_q [$];
    logic [SYS_W-1:0]    sys_q [$];
    int                  cyc_q [$];
    string               name_q [$];

    int                  mismatches = 0;
    int                  protocol_errs = 0;
    int                  neg_count = 0;
    ldpc_pkg::codeword_t last_word = '0;
    logic                end_done = 1'b0;
    ldpc_pkg::codeword_t exp_word;
    logic [SYS_W-1:0]    exp_sys;
    logic [MSG_W-1:0]    full_msg;
    int                  exp_cyc;
    string               exp_name;

    assign mismatch_count = mismatches;
    assign protocol_count = protocol_errs;
    assign pending        = exp_q.size();

    function automatic string test_name(input logic [1:0] id);
        case (id)
            2'd0:    return "isolated";
            2'd1:    return "zero_msg";
            default: return "random";
        endcase
    endfunction

    // zc of 2 so an odd shift swaps the two bits
    function automatic logic [1:0] rotate_block(input logic [1:0] b, input ldpc_pkg::shift_t s);
        if (s == -4'sd1) begin
            return 2'b00;
        end
        if (s[0]) begin
            return {b[0], b[1]};
        end
        return b;
    endfunction

    function automatic ldpc_pkg::codeword_t model_word(input logic [MSG_W-1:0] m);
        logic [1:0]          rs [`LDPC_CORE_ROWS];
        logic [1:0]          p [`LDPC_CORE_ROWS];
        logic [1:0]          total;
        logic [1:0]          acc;
        ldpc_pkg::codeword_t w;
        w     = '0;
        total = '0;
        for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
            rs[r] = '0;
            for (int c = 0; c < `LDPC_KB; c++) begin
                rs[r] ^= rotate_block(m[c*ZC +: ZC], ldpc_pkg::bg_core_shift[r][c]);
            end
            total ^= rs[r];
        end
        p[0] = {total[0], total[1]};   // total rotated by one
        p[1] = p[0] ^ rs[0];
        p[2] = p[1] ^ rs[1];
        p[3] = p[0] ^ rs[3];
        w[SYS_W-1:0] = m[MSG_W-1:SYS_LO];
        for (int j = 0; j < `LDPC_CORE_ROWS; j++) begin
            w[SYS_W + j*ZC +: ZC] = p[j];
        end
        for (int i = 0; i < `LDPC_EXT_ROWS; i++) begin
            acc = '0;
            for (int c = 0; c < `LDPC_KB; c++) begin
                acc ^= rotate_block(m[c*ZC +: ZC], ldpc_pkg::bg_ext_msg_shift[i][c]);
            end
            for (int j = 0; j < `LDPC_CORE_ROWS; j++) begin
                acc ^= rotate_block(p[j], ldpc_pkg::bg_ext_par_shift[i][j]);
            end
            w[SYS_W + CORE_W + i*ZC +: ZC] = acc;
        end
        return w;
    endfunction

    // outputs settled from the last rising edge and inputs ready for the next
    always @(negedge CLK) begin
        neg_count = neg_count + 1;
        if (!RST) begin
            if (valid !== 1'b0 || codeword !== '0) begin
                $display("valid or codeword not cleared during reset");
                protocol_errs++;
            end
        end else if (valid) begin
            if (exp_q.size() == 0) begin
                $display("valid asserted with no outstanding request");
                protocol_errs++;
            end else begin
                exp_word = exp_q.pop_front();
                exp_sys  = sys_q.pop_front();
                exp_cyc  = cyc_q.pop_front();
                exp_name = name_q.pop_front();
                if (neg_count - exp_cyc != 2) begin
                    $display("valid came %0d cycles after its start instead of 2",
                             neg_count - exp_cyc);
                    protocol_errs++;
                end
                if (codeword[SYS_W-1:0] !== exp_sys) begin
                    $display("MISMATCH test=%s/systematic expected=%h actual=%h",
                             exp_name, exp_sys, codeword[SYS_W-1:0]);
                    mismatches++;
                end
                if (codeword !== exp_word) begin
                    $display("MISMATCH test=%s expected=%h actual=%h",
                             exp_name, exp_word, codeword);
                    mismatches++;
                end
            end
            last_word = codeword;
        end else if (codeword !== last_word) begin
            $display("codeword changed while valid was low");
            protocol_errs++;
        end
        if (RST && start) begin
            full_msg = {{(MSG_W - `LDPC_CRC_W - 1){1'b0}}, crc_in, data_in};
            exp_q.push_back(model_word(full_msg));
            sys_q.push_back(full_msg[MSG_W-1:SYS_LO]);
            cyc_q.push_back(neg_count);
            name_q.push_back(test_name(test_id));
        end
        if (end_check && !end_done) begin
            end_done = 1'b1;
            if (exp_q.size() != 0) begin
                $display("%0d requests never produced a valid", exp_q.size());
                protocol_errs++;
            end
        end
    end

endmodule

//--- tests/ldpc_encoder_tb.sv
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpc_encoder_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 2;
    localparam int N_RANDOM     = 400;
    localparam int MARGIN       = 20;
    localparam int DRIVE_DELAY  = 2;

    localparam logic [1:0] ID_ISOLATED = 2'd0;
    localparam logic [1:0] ID_ZERO     = 2'd1;
    localparam logic [1:0] ID_RANDOM   = 2'd2;

    logic                   CLK;
    logic                   RST;
    logic                   start;
    logic                   data_in;
    logic [`LDPC_CRC_W-1:0] crc_in;
    ldpc_pkg::codeword_t    codeword;
    logic                   valid;
    logic [1:0]             test_id;
    logic                   end_check;
    int                     mismatch_count;
    int                     protocol_count;
    int                     pending;
    logic [31:0]            rng_state;

    ldpc_encoder uut (
        .CLK      (CLK),
        .RST      (RST),
        .start    (start),
        .data_in  (data_in),
        .crc_in   (crc_in),
        .codeword (codeword),
        .valid    (valid)
    );

    ldpc_checker u_checker (
        .CLK            (CLK),
        .RST            (RST),
        .start          (start),
        .data_in        (data_in),
        .crc_in         (crc_in),
        .test_id        (test_id),
        .codeword       (codeword),
        .valid          (valid),
        .end_check      (end_check),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .pending        (pending)
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD/2) CLK = ~CLK;
    end

    // hard stop sized from reset, random run and drain margin
    initial begin
        #((RESET_CYCLES + N_RANDOM + MARGIN) * PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drive_cycle(input logic s, input logic d, input logic [`LDPC_CRC_W-1:0] c);
        @(posedge CLK);
        #DRIVE_DELAY;
        start   = s;
        data_in = d;
        crc_in  = c;
    endtask

    task automatic drive_random(input logic s);
        rng_state = xorshift32(rng_state);
        drive_cycle(s, rng_state[9], rng_state[31:16]);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending != 0 && n < 8) begin
            @(posedge CLK);
            n++;
        end
    endtask

    initial begin
        RST       = 1'b0;
        start     = 1'b0;
        data_in   = 1'b0;
        crc_in    = '0;
        test_id   = ID_ISOLATED;
        end_check = 1'b0;
        rng_state = 32'ha2bad3a5;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        RST = 1'b1;

        drive_random(1'b1);   // lone request, then idle
        repeat (4) drive_cycle(1'b0, 1'b0, '0);
        wait_drain();

        test_id = ID_ZERO;
        drive_cycle(1'b1, 1'b0, '0);
        repeat (3) drive_cycle(1'b0, 1'b0, '0);
        wait_drain();

        test_id = ID_RANDOM;
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            drive_random(rng_state[3]);
        end
        drive_cycle(1'b0, 1'b0, '0);
        wait_drain();

        end_check = 1'b1;
        @(negedge CLK);
        #1;
        $display("checker errors: mismatches=%0d protocol=%0d", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- ldpc_enc.f
+incdir+include
logic/ldpc_pkg.sv
logic/ldpc_core_parity.sv
logic/ldpc_ext_parity.sv
logic/ldpc_encoder.sv
tests/ldpc_properties.sv
tests/ldpc_checker.sv
tests/ldpc_encoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the LDPC encoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
    --top-module ldpc_encoder_tb \
    --Mdir obj_dir -o ldpc_sim \
    -f ldpc_enc.f

sim_status=0
./obj_dir/ldpc_sim > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log || [ "$sim_status" -ne 0 ]; then
    echo "simulation reported failure"
    exit 1
fi

exit 0
